//--- axi_bus_pkg.sv
/*
 * AXI4 write-channel field widths and the fixed encodings the bridge drives.
 * Referenced by scoped name from the engine and top level.
 */
package axi_bus_pkg;

   localparam int axi_len_w = 8;
   localparam int axi_id_w  = 1;

   typedef logic [2:0] axi_size_t;
   typedef logic [1:0] axi_burst_t;
   typedef logic [3:0] axi_cache_t;
   typedef logic [2:0] axi_prot_t;
   typedef logic [3:0] axi_qos_t;

   // 4-byte beats
   localparam axi_size_t axi_size_4b = 3'd2;
   // Incrementing bursts only
   localparam axi_burst_t axi_burst_incr = 2'd1;
   // Modifiable, non-bufferable
   localparam axi_cache_t axi_cache_mod = 4'b0010;
   // Unprivileged, non-secure, data access
   localparam axi_prot_t axi_prot_ns = 3'b010;

endpackage

//--- axis2axi_pkg.sv
/*
 * Stream-to-AXI bridge definitions: data word, write engine states, page size.
 */
package axis2axi_pkg;

   localparam int data_w         = 32;
   localparam int bytes_per_word = data_w / 8;

   // No burst may cross this boundary
   localparam int page_bytes = 4096;

   typedef logic [data_w-1:0] word_t;

   typedef enum logic [1:0] {
      wait_data      = 2'd0,
      start_transfer = 2'd1,
      transfer       = 2'd2,
      wait_bresp     = 2'd3
   } wr_state_t;

endpackage

//--- fifo_ram_2p.sv
/*
 * Two-port RAM used as FIFO storage. One write port, one read port whose
 * output register only loads when r_en_i is high.
 */
`timescale 1ns/1ps

module fifo_ram_2p #(
   parameter int ADDR_W = 4
) (
   input  logic                clk_i,
   input  logic                w_en_i,
   input  logic [ADDR_W-1:0]   w_addr_i,
   input  axis2axi_pkg::word_t w_data_i,
   input  logic                r_en_i,
   input  logic [ADDR_W-1:0]   r_addr_i,
   output axis2axi_pkg::word_t r_data_o
);

   axis2axi_pkg::word_t mem [2**ADDR_W];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // Read data holds until the next read strobe
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

//--- fifo_sync.sv
/*
 * Synchronous FIFO controller with a level output. Storage lives outside,
 * reached through the ext_mem port; read data arrives one cycle after r_en_i.
 */
`timescale 1ns/1ps

module fifo_sync #(
   parameter int ADDR_W = 4
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   // Write side
   input  logic                w_en_i,
   input  axis2axi_pkg::word_t w_data_i,
   output logic                w_full_o,
   // Read side
   input  logic                r_en_i,
   output axis2axi_pkg::word_t r_data_o,
   output logic                r_empty_o,
   output logic [ADDR_W:0]     level_o,
   // External RAM
   output logic                ext_mem_w_en_o,
   output logic [ADDR_W-1:0]   ext_mem_w_addr_o,
   output axis2axi_pkg::word_t ext_mem_w_data_o,
   output logic                ext_mem_r_en_o,
   output logic [ADDR_W-1:0]   ext_mem_r_addr_o,
   input  axis2axi_pkg::word_t ext_mem_r_data_i
);

   localparam int depth = 2**ADDR_W;

   logic [ADDR_W-1:0] w_ptr_q;
   logic [ADDR_W-1:0] r_ptr_q;
   logic [ADDR_W:0]   level_q;
   logic              w_do;
   logic              r_do;

   assign w_full_o  = (level_q == (ADDR_W+1)'(depth));
   assign r_empty_o = (level_q == '0);
   assign level_o   = level_q;

   // Writes when full and reads when empty are dropped
   assign w_do = w_en_i && !w_full_o;
   assign r_do = r_en_i && !r_empty_o;

   assign ext_mem_w_en_o   = w_do;
   assign ext_mem_w_addr_o = w_ptr_q;
   assign ext_mem_w_data_o = w_data_i;
   assign ext_mem_r_en_o   = r_do;
   assign ext_mem_r_addr_o = r_ptr_q;
   assign r_data_o         = ext_mem_r_data_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (w_do) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (r_do) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
         // Simultaneous read and write leaves the level unchanged
         case ({w_do, r_do})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

endmodule

//--- axis2axi_in.sv
/*
 * Write engine: drains buffered stream words as incrementing AXI4 write
 * bursts, one burst in flight, never crossing a 4 KB page.
 */
`timescale 1ns/1ps

module axis2axi_in #(
   parameter int AXI_ADDR_W = 16,
   parameter int BURST_W    = 3
) (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   // Stream activity, used to detect the tail of the stream
   input  logic                                axis_in_valid_i,
   // Config
   input  logic [AXI_ADDR_W-1:0]               config_in_addr_i,
   input  logic                                config_in_valid_i,
   output logic                                config_in_ready_o,
   // AXI write address
   output logic [AXI_ADDR_W-1:0]               axi_awaddr_o,
   output logic [axi_bus_pkg::axi_len_w-1:0]   axi_awlen_o,
   output logic                                axi_awvalid_o,
   input  logic                                axi_awready_i,
   output logic [axi_bus_pkg::axi_id_w-1:0]    axi_awid_o,
   output axi_bus_pkg::axi_size_t              axi_awsize_o,
   output axi_bus_pkg::axi_burst_t             axi_awburst_o,
   output logic                                axi_awlock_o,
   output axi_bus_pkg::axi_cache_t             axi_awcache_o,
   output axi_bus_pkg::axi_prot_t              axi_awprot_o,
   output axi_bus_pkg::axi_qos_t               axi_awqos_o,
   // AXI write data
   output axis2axi_pkg::word_t                 axi_wdata_o,
   output logic [axis2axi_pkg::bytes_per_word-1:0] axi_wstrb_o,
   output logic                                axi_wlast_o,
   output logic                                axi_wvalid_o,
   input  logic                                axi_wready_i,
   // AXI write response
   input  logic                                axi_bvalid_i,
   output logic                                axi_bready_o,
   // FIFO
   input  logic [BURST_W+1:0]                  fifo_level_i,
   input  logic                                fifo_empty_i,
   input  axis2axi_pkg::word_t                 fifo_data_i,
   output logic                                fifo_r_en_o
);

   localparam int burst_max  = 2**BURST_W;
   localparam int lvl_w      = BURST_W + 2;
   localparam int len_w      = axi_bus_pkg::axi_len_w;
   localparam int page_w     = $clog2(axis2axi_pkg::page_bytes);
   localparam int byte_shift = $clog2(axis2axi_pkg::bytes_per_word);

   axis2axi_pkg::wr_state_t state_q;
   axis2axi_pkg::wr_state_t state_d;
   logic [AXI_ADDR_W-1:0]   addr_q;
   logic [AXI_ADDR_W-1:0]   addr_d;
   logic [AXI_ADDR_W-1:0]   burst_bytes;
   logic [BURST_W:0]        awlen_q;
   logic [BURST_W:0]        beat_cnt_q;
   logic [BURST_W:0]        len_nb;
   logic [BURST_W:0]        burst_len;
   logic                    full_ok;
   logic                    tail_ok;
   logic                    start;
   logic                    beat_ok;
   logic                    last_beat;

   // Fixed AXI fields
   assign axi_awid_o    = '0;
   assign axi_awsize_o  = axi_bus_pkg::axi_size_4b;
   assign axi_awburst_o = axi_bus_pkg::axi_burst_incr;
   assign axi_awlock_o  = 1'b0;
   assign axi_awcache_o = axi_bus_pkg::axi_cache_mod;
   assign axi_awprot_o  = axi_bus_pkg::axi_prot_ns;
   assign axi_awqos_o   = '0;
   assign axi_wstrb_o   = '1;
   assign axi_bready_o  = 1'b1;

   // Full burst when enough is buffered, else flush the tail once the stream idles
   assign full_ok = (fifo_level_i >= lvl_w'(burst_max));
   assign tail_ok = (fifo_level_i != '0) && !full_ok && !axis_in_valid_i;
   assign start   = (state_q == axis2axi_pkg::wait_data) && (full_ok || tail_ok);
   assign len_nb  = full_ok ? (BURST_W+1)'(burst_max) : fifo_level_i[BURST_W:0];

   generate
      if (AXI_ADDR_W > page_w) begin : g_page_clip
         logic [page_w:0] words_left;
         logic [page_w:0] len_ext;

         // Words remaining before the next page boundary
         assign words_left = ((page_w+1)'(axis2axi_pkg::page_bytes)
                              - {1'b0, addr_q[page_w-1:0]}) >> byte_shift;
         assign len_ext    = (page_w+1)'(len_nb);
         assign burst_len  = (len_ext > words_left) ? words_left[BURST_W:0] : len_nb;
      end else begin : g_no_clip
         // Address space smaller than a page, nothing to clip
         assign burst_len = len_nb;
      end
   endgenerate

   assign axi_awvalid_o = (state_q == axis2axi_pkg::start_transfer);
   // Burst never exceeds buffered data, so wvalid can stay up all burst
   assign axi_wvalid_o  = (state_q == axis2axi_pkg::transfer);
   assign beat_ok       = axi_wvalid_o && axi_wready_i;
   assign last_beat     = (beat_cnt_q == awlen_q);
   assign axi_wlast_o   = axi_wvalid_o && last_beat;
   assign axi_awaddr_o  = addr_q;
   assign axi_awlen_o   = len_w'(awlen_q);
   assign axi_wdata_o   = fifo_data_i;

   // First read at start, then one per accepted non-last beat
   assign fifo_r_en_o = start || (beat_ok && !last_beat);

   assign config_in_ready_o = fifo_empty_i && (state_q == axis2axi_pkg::wait_data);

   assign burst_bytes = (AXI_ADDR_W'(awlen_q) + 1'b1) << byte_shift;

   always_comb begin
      state_d = state_q;
      addr_d  = addr_q;
      if (config_in_valid_i) begin
         addr_d = config_in_addr_i;
      end
      case (state_q)
         axis2axi_pkg::wait_data: begin
            if (start) begin
               state_d = axis2axi_pkg::start_transfer;
            end
         end
         axis2axi_pkg::start_transfer: begin
            if (axi_awready_i) begin
               state_d = axis2axi_pkg::transfer;
            end
         end
         axis2axi_pkg::transfer: begin
            if (beat_ok && last_beat) begin
               addr_d  = addr_q + burst_bytes;
               state_d = axis2axi_pkg::wait_bresp;
            end
         end
         axis2axi_pkg::wait_bresp: begin
            if (axi_bvalid_i) begin
               state_d = axis2axi_pkg::wait_data;
            end
         end
         default: state_d = axis2axi_pkg::wait_data;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= axis2axi_pkg::wait_data;
         addr_q     <= '0;
         awlen_q    <= '0;
         beat_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         addr_q  <= addr_d;
         if (start) begin
            awlen_q <= burst_len - 1'b1;
         end
         if (state_q == axis2axi_pkg::wait_data) begin
            beat_cnt_q <= '0;
         end else if (beat_ok) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end
      end
   end

endmodule

//--- axis2axi_top.sv
/*
 * Stream-to-AXI4 write bridge top level: FIFO, its RAM and the write engine.
 */
`timescale 1ns/1ps

module axis2axi_top #(
   parameter int AXI_ADDR_W = 16,
   parameter int BURST_W    = 3
) (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  axis2axi_pkg::word_t                 axis_in_data_i,
   input  logic                                axis_in_valid_i,
   output logic                                axis_in_ready_o,
   input  logic [AXI_ADDR_W-1:0]               config_in_addr_i,
   input  logic                                config_in_valid_i,
   output logic                                config_in_ready_o,
   output logic [AXI_ADDR_W-1:0]               axi_awaddr_o,
   output logic [axi_bus_pkg::axi_len_w-1:0]   axi_awlen_o,
   output logic                                axi_awvalid_o,
   input  logic                                axi_awready_i,
   output logic [axi_bus_pkg::axi_id_w-1:0]    axi_awid_o,
   output axi_bus_pkg::axi_size_t              axi_awsize_o,
   output axi_bus_pkg::axi_burst_t             axi_awburst_o,
   output logic                                axi_awlock_o,
   output axi_bus_pkg::axi_cache_t             axi_awcache_o,
   output axi_bus_pkg::axi_prot_t              axi_awprot_o,
   output axi_bus_pkg::axi_qos_t               axi_awqos_o,
   output axis2axi_pkg::word_t                 axi_wdata_o,
   output logic [axis2axi_pkg::bytes_per_word-1:0] axi_wstrb_o,
   output logic                                axi_wlast_o,
   output logic                                axi_wvalid_o,
   input  logic                                axi_wready_i,
   input  logic                                axi_bvalid_i,
   output logic                                axi_bready_o
);

   // FIFO holds two full bursts
   localparam int addr_w = BURST_W + 1;

   logic                fifo_full;
   logic                fifo_empty;
   logic [addr_w:0]     fifo_level;
   logic                fifo_r_en;
   axis2axi_pkg::word_t fifo_r_data;
   logic                mem_w_en;
   logic [addr_w-1:0]   mem_w_addr;
   axis2axi_pkg::word_t mem_w_data;
   logic                mem_r_en;
   logic [addr_w-1:0]   mem_r_addr;
   axis2axi_pkg::word_t mem_r_data;

   // Back-pressure on the stream comes straight from the FIFO
   assign axis_in_ready_o = !fifo_full;

   fifo_ram_2p #(
      .ADDR_W(addr_w)
   ) ram_i (
      .clk_i   (clk_i),
      .w_en_i  (mem_w_en),
      .w_addr_i(mem_w_addr),
      .w_data_i(mem_w_data),
      .r_en_i  (mem_r_en),
      .r_addr_i(mem_r_addr),
      .r_data_o(mem_r_data)
   );

   fifo_sync #(
      .ADDR_W(addr_w)
   ) fifo_i (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .w_en_i          (axis_in_valid_i),
      .w_data_i        (axis_in_data_i),
      .w_full_o        (fifo_full),
      .r_en_i          (fifo_r_en),
      .r_data_o        (fifo_r_data),
      .r_empty_o       (fifo_empty),
      .level_o         (fifo_level),
      .ext_mem_w_en_o  (mem_w_en),
      .ext_mem_w_addr_o(mem_w_addr),
      .ext_mem_w_data_o(mem_w_data),
      .ext_mem_r_en_o  (mem_r_en),
      .ext_mem_r_addr_o(mem_r_addr),
      .ext_mem_r_data_i(mem_r_data)
   );

   axis2axi_in #(
      .AXI_ADDR_W(AXI_ADDR_W),
      .BURST_W   (BURST_W)
   ) engine_i (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .axis_in_valid_i  (axis_in_valid_i),
      .config_in_addr_i (config_in_addr_i),
      .config_in_valid_i(config_in_valid_i),
      .config_in_ready_o(config_in_ready_o),
      .axi_awaddr_o     (axi_awaddr_o),
      .axi_awlen_o      (axi_awlen_o),
      .axi_awvalid_o    (axi_awvalid_o),
      .axi_awready_i    (axi_awready_i),
      .axi_awid_o       (axi_awid_o),
      .axi_awsize_o     (axi_awsize_o),
      .axi_awburst_o    (axi_awburst_o),
      .axi_awlock_o     (axi_awlock_o),
      .axi_awcache_o    (axi_awcache_o),
      .axi_awprot_o     (axi_awprot_o),
      .axi_awqos_o      (axi_awqos_o),
      .axi_wdata_o      (axi_wdata_o),
      .axi_wstrb_o      (axi_wstrb_o),
      .axi_wlast_o      (axi_wlast_o),
      .axi_wvalid_o     (axi_wvalid_o),
      .axi_wready_i     (axi_wready_i),
      .axi_bvalid_i     (axi_bvalid_i),
      .axi_bready_o     (axi_bready_o),
      .fifo_level_i     (fifo_level),
      .fifo_empty_i     (fifo_empty),
      .fifo_data_i      (fifo_r_data),
      .fifo_r_en_o      (fifo_r_en)
   );

endmodule

//--- axis2axi_props.sv
/*
 * Concurrent checks on the write engine's AXI handshakes, bound into every
 * axis2axi_in instance.
 */
`timescale 1ns/1ps

module axis2axi_props (
   input logic clk_i,
   input logic rst_n_i,
   input logic awvalid_i,
   input logic awready_i,
   input logic wvalid_i,
   input logic wlast_i
);

   // Address held until the slave takes it
   aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      awvalid_i && !awready_i |=> awvalid_i)
      else $error("awvalid dropped before awready");

   aw_w_apart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(awvalid_i && wvalid_i))
      else $error("awvalid and wvalid high together");

   wlast_in_beat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wlast_i |-> wvalid_i)
      else $error("wlast without wvalid");

   reset_idle: assert property (@(posedge clk_i)
      !rst_n_i |=> !awvalid_i && !wvalid_i)
      else $error("AXI valid high right after reset");

endmodule

bind axis2axi_in axis2axi_props props_i (
   .clk_i    (clk_i),
   .rst_n_i  (rst_n_i),
   .awvalid_i(axi_awvalid_o),
   .awready_i(axi_awready_i),
   .wvalid_i (axi_wvalid_o),
   .wlast_i  (axi_wlast_o)
);

//--- tb_axis2axi.sv
/*
 * Testbench for the stream-to-AXI4 write bridge. A random stream source and an
 * AXI slave with random stalls; every beat is checked against a queue model.
 */
`timescale 1ns/1ps

module tb_axis2axi;

   localparam int addr_w     = 16;
   localparam int burst_w    = 3;
   localparam int n_words    = 300;
   localparam int max_cycles = n_words * 4 + 2000;
   localparam int page_size  = 4096;

   // 32 words below a page boundary
   localparam logic [addr_w-1:0] base_addr = 16'h0F80;
   localparam logic [addr_w-1:0] page_mask = ~addr_w'(page_size - 1);

   logic                                    clk;
   logic                                    rst_n;
   axis2axi_pkg::word_t                     axis_in_data;
   logic                                    axis_in_valid;
   logic                                    axis_in_ready;
   logic [addr_w-1:0]                       config_in_addr;
   logic                                    config_in_valid;
   logic                                    config_in_ready;
   logic [addr_w-1:0]                       axi_awaddr;
   logic [axi_bus_pkg::axi_len_w-1:0]       axi_awlen;
   logic                                    axi_awvalid;
   logic                                    axi_awready;
   logic [axi_bus_pkg::axi_id_w-1:0]        axi_awid;
   axi_bus_pkg::axi_size_t                  axi_awsize;
   axi_bus_pkg::axi_burst_t                 axi_awburst;
   logic                                    axi_awlock;
   axi_bus_pkg::axi_cache_t                 axi_awcache;
   axi_bus_pkg::axi_prot_t                  axi_awprot;
   axi_bus_pkg::axi_qos_t                   axi_awqos;
   axis2axi_pkg::word_t                     axi_wdata;
   logic [axis2axi_pkg::bytes_per_word-1:0] axi_wstrb;
   logic                                    axi_wlast;
   logic                                    axi_wvalid;
   logic                                    axi_wready;
   logic                                    axi_bvalid;
   logic                                    axi_bready;

   // Model: every accepted stream word, in order
   axis2axi_pkg::word_t exp_q[$];
   logic [addr_w-1:0]   exp_addr;
   logic [addr_w-1:0]   last_byte;
   logic                stream_taken;
   int                  cycles;
   int                  n_sent;
   int                  n_checked;
   int                  beats;
   int                  cur_len;
   int                  b_wait;

   axis2axi_top #(
      .AXI_ADDR_W(addr_w),
      .BURST_W   (burst_w)
   ) dut_i (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .axis_in_data_i   (axis_in_data),
      .axis_in_valid_i  (axis_in_valid),
      .axis_in_ready_o  (axis_in_ready),
      .config_in_addr_i (config_in_addr),
      .config_in_valid_i(config_in_valid),
      .config_in_ready_o(config_in_ready),
      .axi_awaddr_o     (axi_awaddr),
      .axi_awlen_o      (axi_awlen),
      .axi_awvalid_o    (axi_awvalid),
      .axi_awready_i    (axi_awready),
      .axi_awid_o       (axi_awid),
      .axi_awsize_o     (axi_awsize),
      .axi_awburst_o    (axi_awburst),
      .axi_awlock_o     (axi_awlock),
      .axi_awcache_o    (axi_awcache),
      .axi_awprot_o     (axi_awprot),
      .axi_awqos_o      (axi_awqos),
      .axi_wdata_o      (axi_wdata),
      .axi_wstrb_o      (axi_wstrb),
      .axi_wlast_o      (axi_wlast),
      .axi_wvalid_o     (axi_wvalid),
      .axi_wready_i     (axi_wready),
      .axi_bvalid_i     (axi_bvalid),
      .axi_bready_o     (axi_bready)
   );

   always #10 clk = ~clk;

   task automatic stop_run();
      $display("sim failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input axis2axi_pkg::word_t got, input axis2axi_pkg::word_t exp,
                             input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s is %08h, expected %08h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_addr(input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s is %04h, expected %04h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_len(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_field(input logic [3:0] got, input logic [3:0] exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
         stop_run();
      end
   endtask

   // Runs on the falling edge, before the outputs are sampled
   task automatic drive_inputs();
      // A word stays on the bus until it is taken
      if (!axis_in_valid || stream_taken) begin
         if (n_sent < n_words && $urandom_range(3) != 0) begin
            axis_in_valid = 1'b1;
            axis_in_data  = $urandom();
         end else begin
            axis_in_valid = 1'b0;
         end
      end
      axi_awready = ($urandom_range(3) != 0);
      axi_wready  = ($urandom_range(3) != 0);
      axi_bvalid  = 1'b0;
      if (b_wait > 0) begin
         b_wait = b_wait - 1;
         if (b_wait == 0) begin
            axi_bvalid = 1'b1;
         end
      end
   endtask

   // Handshakes seen here complete on the next rising edge
   task automatic sample_outputs();
      axis2axi_pkg::word_t exp_word;
      stream_taken = axis_in_valid && axis_in_ready;
      if (stream_taken) begin
         exp_q.push_back(axis_in_data);
         n_sent = n_sent + 1;
      end
      if (axi_awvalid && axi_awready) begin
         check_addr(axi_awaddr, exp_addr, "awaddr");
         check_field(4'(axi_awsize), 4'h2, "awsize");
         check_field(4'(axi_awburst), 4'h1, "awburst");
         check_field(4'(axi_awid), 4'h0, "awid");
         check_field(4'(axi_awlock), 4'h0, "awlock");
         check_field(4'(axi_awcache), 4'h2, "awcache");
         check_field(4'(axi_awprot), 4'h2, "awprot");
         check_field(4'(axi_awqos), 4'h0, "awqos");
         if (axi_awlen > 8'd7) begin
            $display("ERR %0t: awlen %0d is longer than 8 beats", $time, axi_awlen);
            stop_run();
         end
         // Last byte of the burst must sit in the start page
         last_byte = axi_awaddr + addr_w'((int'(axi_awlen) + 1) * 4) - addr_w'(1);
         check_addr(last_byte & page_mask, axi_awaddr & page_mask, "burst end page");
         cur_len = int'(axi_awlen) + 1;
         beats   = 0;
      end
      if (axi_wvalid && axi_wready) begin
         if (exp_q.size() == 0) begin
            $display("An AXI write beat arrived with no stream word left to match it");
            stop_run();
         end
         exp_word = exp_q.pop_front();
         check_word(axi_wdata, exp_word, "wdata");
         check_field(4'(axi_wstrb), 4'hf, "wstrb");
         beats     = beats + 1;
         n_checked = n_checked + 1;
         exp_addr  = exp_addr + addr_w'(4);
         if (axi_wlast) begin
            check_len(8'(beats), 8'(cur_len), "beats per burst");
            b_wait = $urandom_range(3, 1);
         end else if (beats >= cur_len) begin
            $display("ERR %0t: no wlast on beat %0d of a %0d-beat burst", $time, beats, cur_len);
            stop_run();
         end
      end
   endtask

   initial begin
      void'($urandom(22332));
      clk             = 1'b0;
      rst_n           = 1'b0;
      axis_in_data    = '0;
      axis_in_valid   = 1'b0;
      config_in_addr  = '0;
      config_in_valid = 1'b0;
      axi_awready     = 1'b0;
      axi_wready      = 1'b0;
      axi_bvalid      = 1'b0;
      stream_taken    = 1'b0;
      exp_addr        = '0;
      last_byte       = '0;
      cycles          = 0;
      n_sent          = 0;
      n_checked       = 0;
      beats           = 0;
      cur_len         = 0;
      b_wait          = 0;

      repeat (3) @(negedge clk);
      check_field(4'(axi_awvalid), 4'h0, "awvalid in reset");
      check_field(4'(axi_wvalid), 4'h0, "wvalid in reset");
      check_field(4'(axi_wlast), 4'h0, "wlast in reset");
      check_field(4'(axis_in_ready), 4'h1, "stream ready in reset");
      check_field(4'(config_in_ready), 4'h1, "config ready in reset");
      check_addr(axi_awaddr, '0, "awaddr in reset");
      rst_n = 1'b1;

      // Base address is loaded once while idle
      @(negedge clk);
      check_field(4'(config_in_ready), 4'h1, "config ready before base load");
      config_in_addr  = base_addr;
      config_in_valid = 1'b1;
      exp_addr        = base_addr;
      @(negedge clk);
      config_in_valid = 1'b0;

      while (!(n_checked == n_words && config_in_ready)) begin
         drive_inputs();
         sample_outputs();
         cycles = cycles + 1;
         if (cycles > max_cycles) begin
            $display("Timeout: only %0d of %0d words written after %0d cycles",
                     n_checked, n_words, cycles);
            stop_run();
         end
         @(negedge clk);
      end

      check_field(4'(axi_bready), 4'h1, "bready");
      // Engine points just past the last word written
      check_addr(axi_awaddr, exp_addr, "address after the run");
      $display("sim passed");
      $finish;
   end

endmodule

//--- sources.f
axi_bus_pkg.sv
axis2axi_pkg.sv
fifo_ram_2p.sv
fifo_sync.sv
axis2axi_in.sv
axis2axi_top.sv
axis2axi_props.sv
tb_axis2axi.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the bridge testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_axis2axi \
   -Mdir obj_dir -o sim_axis2axi
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

sim_out="$(./obj_dir/sim_axis2axi 2>&1)"
run_status=$?
echo "$sim_out"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
   exit 0
fi
echo "Pass line not found in simulation output"
exit 1
